// ==== verilog/raster_mem_pkg.sv ====
// Raster memory subsystem shared definitions
// Word and address types, the command header layout and the IDs of the
// requesters that share the external memory bus
package raster_mem_pkg;

    // One data word on every stream and on the memory bus
    typedef logic [31:0] word_t;

    // Word address on the memory bus
    typedef logic [31:0] addr_t;

    // Command opcode in the header word
    typedef enum logic [3:0]
    {
        OP_STORE = 4'h1,
        OP_LOAD  = 4'h2
    } cmd_op_t;

    // Header layout: opcode in bits 31..28, word count in bits 15..0
    localparam int CMD_OP_LSB      = 28;
    localparam int CMD_COUNT_WIDTH = 16;

    typedef logic [CMD_COUNT_WIDTH-1:0] cmd_count_t;

    // Requesters on the shared memory bus, in round-robin order
    typedef enum logic [1:0]
    {
        REQ_DMA = 2'd0,
        REQ_TEX = 2'd1,
        REQ_FB  = 2'd2
    } req_id_t;

endpackage

// ==== verilog/cmd_dma.sv ====
// Command DMA engine
// Executes store and load commands from the command stream. A store
// writes the data words that follow the address word, a load reads
// words from memory and sends them out on the response stream.
`timescale 1ns/1ps

module cmd_dma import raster_mem_pkg::*;
(
    input  logic  aclk,
    input  logic  rst,

    input  logic  cmd_valid,
    input  logic  cmd_last,
    input  word_t cmd_data,
    output logic  cmd_ready,

    output logic  rsp_valid,
    output logic  rsp_last,
    output word_t rsp_data,
    input  logic  rsp_ready,

    output logic  dma_req,
    output logic  dma_we,
    output addr_t dma_addr,
    output word_t dma_wdata,
    input  logic  dma_ack,
    input  word_t mem_rdata
);

    typedef enum logic [2:0]
    {
        HEADER,
        ADDRESS,
        STORE_WORD,
        STORE_WAIT,
        LOAD_ISSUE,
        LOAD_SEND
    } dma_state_t;

    dma_state_t state;
    dma_state_t state_next;
    cmd_op_t    op;
    cmd_count_t count;
    logic       store_last;
    logic       cmd_fire;
    logic       rsp_fire;
    logic       final_word;

    assign cmd_fire   = cmd_valid && cmd_ready;
    assign rsp_fire   = rsp_valid && rsp_ready;
    assign final_word = (count == cmd_count_t'(1));

    always_comb
    begin
        state_next = state;
        unique case (state)
            HEADER:
                if (cmd_fire) state_next = ADDRESS;
            ADDRESS:
                if (cmd_fire) state_next = (op == OP_STORE) ? STORE_WORD : LOAD_ISSUE;
            STORE_WORD:
                if (cmd_fire) state_next = STORE_WAIT;
            // A word marked last ends the store even if the count is not used up
            STORE_WAIT:
                if (dma_ack) state_next = (final_word || store_last) ? HEADER : STORE_WORD;
            LOAD_ISSUE:
                if (dma_ack) state_next = LOAD_SEND;
            LOAD_SEND:
                if (rsp_fire) state_next = rsp_last ? HEADER : LOAD_ISSUE;
            default:
                state_next = HEADER;
        endcase
    end

    // Ready is registered so that it stays low through reset
    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            state     <= HEADER;
            cmd_ready <= 1'b0;
        end
        else
        begin
            state     <= state_next;
            cmd_ready <= state_next inside {HEADER, ADDRESS, STORE_WORD};
        end
    end

    always_ff @(posedge aclk)
    begin
        if (state == HEADER && cmd_fire)
        begin
            op    <= cmd_op_t'(cmd_data[CMD_OP_LSB +: $bits(cmd_op_t)]);
            count <= cmd_data[CMD_COUNT_WIDTH-1:0];
        end
        if (state == ADDRESS && cmd_fire)
            dma_addr <= cmd_data;
        if (state == STORE_WORD && cmd_fire)
        begin
            dma_wdata  <= cmd_data;
            store_last <= cmd_last;
        end
        // One word done, either written or handed to the response stream
        if ((state == STORE_WAIT && dma_ack) || rsp_fire)
        begin
            dma_addr <= dma_addr + 1'b1;
            count    <= count - 1'b1;
        end
        if (state == LOAD_ISSUE && dma_ack)
        begin
            rsp_data <= mem_rdata;
            rsp_last <= final_word;
        end
    end

    assign dma_req   = (state == STORE_WAIT) || (state == LOAD_ISSUE);
    assign dma_we    = (state == STORE_WAIT);
    assign rsp_valid = (state == LOAD_SEND);

    // A zero count would make the engine run through the whole count range
    a_nonzero_count: assert property (@(posedge aclk) disable iff (rst)
        (state == HEADER && cmd_fire) |-> (cmd_data[CMD_COUNT_WIDTH-1:0] != '0))
        else $error("cmd_dma: command header with zero word count");

endmodule

// ==== verilog/texel_fetch.sv ====
// Texel fetch port
// Queues texture word reads and issues them one at a time on the memory
// bus. Data comes back in request order with one tex_rvalid pulse each.
`timescale 1ns/1ps

module texel_fetch import raster_mem_pkg::*;
#(
    parameter int TEX_QUEUE_DEPTH = 4
)
(
    input  logic  aclk,
    input  logic  rst,

    input  logic  tex_req,
    input  addr_t tex_addr,
    output logic  tex_full,
    output logic  tex_rvalid,
    output word_t tex_rdata,

    output logic  tx_req,
    output addr_t tx_addr,
    input  logic  tx_ack,
    input  word_t mem_rdata
);

    // The head entry is the read on the bus, the rest wait behind it
    localparam int SLOTS = TEX_QUEUE_DEPTH + 1;
    localparam int PTR_W = (SLOTS > 1) ? $clog2(SLOTS) : 1;
    localparam int CNT_W = $clog2(SLOTS + 1);

    addr_t            queue [SLOTS];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(SLOTS - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill       <= '0;
            tex_rvalid <= 1'b0;
        end
        else
        begin
            if (tex_req)
                wr_ptr <= next_ptr(wr_ptr);
            if (tx_ack)
                rd_ptr <= next_ptr(rd_ptr);
            case ({tex_req, tx_ack})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            tex_rvalid <= tx_ack;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (tex_req)
            queue[wr_ptr] <= tex_addr;
        if (tx_ack)
            tex_rdata <= mem_rdata;
    end

    assign tx_req   = (fill != '0);
    assign tx_addr  = queue[rd_ptr];
    assign tex_full = (fill == CNT_W'(SLOTS));

    a_no_push_when_full: assert property (@(posedge aclk) disable iff (rst)
        tex_req |-> !tex_full)
        else $error("texel_fetch: read requested while the queue is full");

endmodule

// ==== verilog/fb_writer.sv ====
// Framebuffer writer
// On a commit, copies fb_size words of the pixel stream to memory from
// fb_addr upward and pulses fb_committed once the last write is acked.
`timescale 1ns/1ps

module fb_writer import raster_mem_pkg::*;
#(
    parameter int FB_SIZE_LG = 16
)
(
    input  logic                  aclk,
    input  logic                  rst,

    input  logic                  commit_fb,
    input  addr_t                 fb_addr,
    input  logic [FB_SIZE_LG-1:0] fb_size,
    output logic                  fb_committed,

    input  logic                  pix_valid,
    input  logic                  pix_last,
    input  word_t                 pix_data,
    output logic                  pix_ready,

    output logic                  fb_req,
    output addr_t                 fb_waddr,
    output word_t                 fb_wdata,
    input  logic                  fb_ack
);

    typedef enum logic [1:0]
    {
        IDLE,
        TAKE,
        WRITE,
        DONE
    } fb_state_t;

    fb_state_t             state;
    logic [FB_SIZE_LG-1:0] remaining;
    logic                  frame_last;
    logic                  pix_fire;

    assign pix_fire = pix_valid && pix_ready;

    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            state <= IDLE;
        end
        else
        begin
            unique case (state)
                IDLE:
                    if (commit_fb) state <= (fb_size == '0) ? DONE : TAKE;
                TAKE:
                    if (pix_fire) state <= WRITE;
                // The stream may close the frame early with pix_last
                WRITE:
                    if (fb_ack) state <= (remaining == 1 || frame_last) ? DONE : TAKE;
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk)
    begin
        if (state == IDLE && commit_fb)
        begin
            fb_waddr  <= fb_addr;
            remaining <= fb_size;
        end
        if (pix_fire)
        begin
            fb_wdata   <= pix_data;
            frame_last <= pix_last;
        end
        if (state == WRITE && fb_ack)
        begin
            fb_waddr  <= fb_waddr + 1'b1;
            remaining <= remaining - 1'b1;
        end
    end

    // A pixel is only taken while no write is on the bus
    assign pix_ready    = (state == TAKE);
    assign fb_req       = (state == WRITE);
    assign fb_committed = (state == DONE);

    a_commit_when_idle: assert property (@(posedge aclk) disable iff (rst)
        commit_fb |-> (state == IDLE))
        else $error("fb_writer: commit while the previous frame is still being written");

endmodule

// ==== verilog/mem_arbiter.sv ====
// Memory bus arbiter
// Round-robin arbitration of the DMA, texel and framebuffer requesters
// onto one single-beat request/acknowledge memory bus.
`timescale 1ns/1ps

module mem_arbiter import raster_mem_pkg::*;
(
    input  logic  aclk,
    input  logic  rst,

    input  logic  dma_req,
    input  logic  dma_we,
    input  addr_t dma_addr,
    input  word_t dma_wdata,
    output logic  dma_ack,

    input  logic  tx_req,
    input  addr_t tx_addr,
    output logic  tx_ack,

    input  logic  fb_req,
    input  addr_t fb_waddr,
    input  word_t fb_wdata,
    output logic  fb_ack,

    output logic  mem_req,
    output logic  mem_we,
    output addr_t mem_addr,
    output word_t mem_wdata,
    input  logic  mem_ack
);

    // Owner of the transfer on the bus, or of the last one when idle
    req_id_t last_owner;
    req_id_t pick;
    logic    pick_valid;

    // Search starts with the peer after the last owner
    always_comb
    begin
        pick       = last_owner;
        pick_valid = 1'b1;
        unique case (last_owner)
            REQ_DMA:
                if (tx_req) pick = REQ_TEX;
                else if (fb_req) pick = REQ_FB;
                else if (!dma_req) pick_valid = 1'b0;
            REQ_TEX:
                if (fb_req) pick = REQ_FB;
                else if (dma_req) pick = REQ_DMA;
                else if (!tx_req) pick_valid = 1'b0;
            default:
                if (dma_req) pick = REQ_DMA;
                else if (tx_req) pick = REQ_TEX;
                else if (fb_req) pick = REQ_FB;
                else pick_valid = 1'b0;
        endcase
    end

    // Reset sets the last owner to FB so DMA wins the first grant
    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            mem_req    <= 1'b0;
            last_owner <= REQ_FB;
        end
        else if (mem_req)
        begin
            if (mem_ack)
                mem_req <= 1'b0;
        end
        else if (pick_valid)
        begin
            mem_req    <= 1'b1;
            last_owner <= pick;
        end
    end

    // Texel reads never write and framebuffer accesses always write
    always_ff @(posedge aclk)
    begin
        if (!mem_req && pick_valid)
        begin
            unique case (pick)
                REQ_DMA: {mem_we, mem_addr, mem_wdata} <= {dma_we, dma_addr, dma_wdata};
                REQ_TEX: {mem_we, mem_addr, mem_wdata} <= {1'b0, tx_addr, word_t'(0)};
                default: {mem_we, mem_addr, mem_wdata} <= {1'b1, fb_waddr, fb_wdata};
            endcase
        end
    end

    assign dma_ack = mem_req && mem_ack && (last_owner == REQ_DMA);
    assign tx_ack  = mem_req && mem_ack && (last_owner == REQ_TEX);
    assign fb_ack  = mem_req && mem_ack && (last_owner == REQ_FB);

endmodule

// ==== verilog/raster_mem_top.sv ====
// Raster engine memory subsystem top level
// Connects the command DMA engine, the texel fetch port and the
// framebuffer writer to the external memory bus through one arbiter.
`timescale 1ns/1ps

module raster_mem_top import raster_mem_pkg::*;
#(
    parameter int TEX_QUEUE_DEPTH = 4,
    parameter int FB_SIZE_LG      = 16
)
(
    input  logic                  aclk,
    input  logic                  rst,

    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    input  logic                  cmd_last,
    input  word_t                 cmd_data,

    output logic                  rsp_valid,
    input  logic                  rsp_ready,
    output logic                  rsp_last,
    output word_t                 rsp_data,

    input  logic                  tex_req,
    input  addr_t                 tex_addr,
    output logic                  tex_full,
    output logic                  tex_rvalid,
    output word_t                 tex_rdata,

    input  logic                  commit_fb,
    input  addr_t                 fb_addr,
    input  logic [FB_SIZE_LG-1:0] fb_size,
    output logic                  fb_committed,
    input  logic                  pix_valid,
    output logic                  pix_ready,
    input  logic                  pix_last,
    input  word_t                 pix_data,

    output logic                  mem_req,
    output logic                  mem_we,
    output addr_t                 mem_addr,
    output word_t                 mem_wdata,
    input  logic                  mem_ack,
    input  word_t                 mem_rdata
);

    logic  dma_req;
    logic  dma_we;
    addr_t dma_addr;
    word_t dma_wdata;
    logic  dma_ack;

    logic  tx_req;
    addr_t tx_addr;
    logic  tx_ack;

    logic  fb_req;
    addr_t fb_waddr;
    word_t fb_wdata;
    logic  fb_ack;

    cmd_dma u_cmd_dma (
        .aclk(aclk),
        .rst(rst),
        .cmd_valid(cmd_valid),
        .cmd_last(cmd_last),
        .cmd_data(cmd_data),
        .cmd_ready(cmd_ready),
        .rsp_valid(rsp_valid),
        .rsp_last(rsp_last),
        .rsp_data(rsp_data),
        .rsp_ready(rsp_ready),
        .dma_req(dma_req),
        .dma_we(dma_we),
        .dma_addr(dma_addr),
        .dma_wdata(dma_wdata),
        .dma_ack(dma_ack),
        .mem_rdata(mem_rdata)
    );

    texel_fetch #(
        .TEX_QUEUE_DEPTH(TEX_QUEUE_DEPTH)
    ) u_texel_fetch (
        .aclk(aclk),
        .rst(rst),
        .tex_req(tex_req),
        .tex_addr(tex_addr),
        .tex_full(tex_full),
        .tex_rvalid(tex_rvalid),
        .tex_rdata(tex_rdata),
        .tx_req(tx_req),
        .tx_addr(tx_addr),
        .tx_ack(tx_ack),
        .mem_rdata(mem_rdata)
    );

    fb_writer #(
        .FB_SIZE_LG(FB_SIZE_LG)
    ) u_fb_writer (
        .aclk(aclk),
        .rst(rst),
        .commit_fb(commit_fb),
        .fb_addr(fb_addr),
        .fb_size(fb_size),
        .fb_committed(fb_committed),
        .pix_valid(pix_valid),
        .pix_last(pix_last),
        .pix_data(pix_data),
        .pix_ready(pix_ready),
        .fb_req(fb_req),
        .fb_waddr(fb_waddr),
        .fb_wdata(fb_wdata),
        .fb_ack(fb_ack)
    );

    mem_arbiter u_mem_arbiter (
        .aclk(aclk),
        .rst(rst),
        .dma_req(dma_req),
        .dma_we(dma_we),
        .dma_addr(dma_addr),
        .dma_wdata(dma_wdata),
        .dma_ack(dma_ack),
        .tx_req(tx_req),
        .tx_addr(tx_addr),
        .tx_ack(tx_ack),
        .fb_req(fb_req),
        .fb_waddr(fb_waddr),
        .fb_wdata(fb_wdata),
        .fb_ack(fb_ack),
        .mem_req(mem_req),
        .mem_we(mem_we),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_ack(mem_ack)
    );

endmodule

// ==== sim/sim_memory.sv ====
// Behavioral memory for the testbench
// Single-beat request/acknowledge slave that answers each request after
// 0 to 3 idle cycles. Words never written read back as a fill pattern.
`timescale 1ns/1ps

module sim_memory import raster_mem_pkg::*;
#(
    parameter logic [31:0] SEED     = 32'h351d_98fe,
    parameter word_t       FILL_KEY = 32'h5a5a_c3c3
)
(
    input  logic  aclk,
    input  logic  rst,
    input  logic  mem_req,
    input  logic  mem_we,
    input  addr_t mem_addr,
    input  word_t mem_wdata,
    output logic  mem_ack,
    output word_t mem_rdata
);

    word_t  storage [addr_t];
    integer seed;
    logic   busy;
    int     wait_left;
    int     delay;

    function automatic word_t read_word(input addr_t addr);
        if (storage.exists(addr))
            return storage[addr];
        return addr ^ FILL_KEY;
    endfunction

    initial
    begin
        seed      = SEED;
        mem_ack   = 1'b0;
        mem_rdata = '0;
    end

    always @(posedge aclk)
    begin
        if (rst)
        begin
            mem_ack   <= 1'b0;
            busy      <= 1'b0;
            wait_left <= 0;
        end
        else if (mem_ack)
        begin
            // The request is still high in the acknowledge cycle
            mem_ack <= 1'b0;
        end
        else if (mem_req)
        begin
            // A new request draws its delay, a waiting one counts down
            delay = busy ? wait_left : {$random(seed)} % 4;
            if (delay == 0)
            begin
                if (mem_we)
                    storage[mem_addr] = mem_wdata;
                mem_rdata <= read_word(mem_addr);
                mem_ack   <= 1'b1;
                busy      <= 1'b0;
            end
            else
            begin
                busy      <= 1'b1;
                wait_left <= delay - 1;
            end
        end
    end

endmodule

// ==== sim/tb_raster_mem.sv ====
// Testbench for the raster memory subsystem
// Applies a table of stores, loads, texel reads and framebuffer commits,
// checks every result against a reference memory and watches the
// round-robin service of the three requesters on the memory bus.
`timescale 1ns/1ps

module tb_raster_mem import raster_mem_pkg::*;
();

    localparam int    TEX_QUEUE_DEPTH = 4;
    localparam int    FB_SIZE_LG      = 16;
    localparam int    TEX_SLOTS       = TEX_QUEUE_DEPTH + 1;
    localparam int    NUM_STEPS       = 12;
    localparam int    MIX_TEX_COUNT   = 10;
    localparam addr_t MIX_TEX_BASE    = 32'h0000_1000;
    localparam addr_t MIX_FB_OFFSET   = 32'h0000_1000;
    localparam word_t FILL_KEY        = 32'h5a5a_c3c3;
    localparam logic [31:0] SEED      = 32'h351d_98fe;

    typedef enum logic [2:0]
    {
        K_STORE,
        K_LOAD,
        K_TEXEL,
        K_COMMIT,
        K_MIX
    } step_kind_t;

    typedef struct packed
    {
        step_kind_t  kind;
        addr_t       addr;
        logic [15:0] count;
        word_t       seed;
    } step_t;

    logic                  aclk;
    logic                  rst;
    logic                  cmd_valid;
    logic                  cmd_ready;
    logic                  cmd_last;
    word_t                 cmd_data;
    logic                  rsp_valid;
    logic                  rsp_ready;
    logic                  rsp_last;
    word_t                 rsp_data;
    logic                  tex_req;
    addr_t                 tex_addr;
    logic                  tex_full;
    logic                  tex_rvalid;
    word_t                 tex_rdata;
    logic                  commit_fb;
    addr_t                 fb_addr;
    logic [FB_SIZE_LG-1:0] fb_size;
    logic                  fb_committed;
    logic                  pix_valid;
    logic                  pix_ready;
    logic                  pix_last;
    word_t                 pix_data;
    logic                  mem_req;
    logic                  mem_we;
    addr_t                 mem_addr;
    word_t                 mem_wdata;
    logic                  mem_ack;
    word_t                 mem_rdata;

    step_t    steps [NUM_STEPS];
    word_t    ref_mem [addr_t];
    word_t    tex_expect [$];
    integer   seed;
    int       tex_pushes;
    int       tex_pops;
    logic     saw_full;
    int       commit_count;
    int       commit_pulses;
    int       error_count;
    int       limit_cycles;
    int       waits [3];
    logic [2:0] reqs;
    logic [2:0] acks;

    raster_mem_top #(
        .TEX_QUEUE_DEPTH(TEX_QUEUE_DEPTH),
        .FB_SIZE_LG(FB_SIZE_LG)
    ) u_dut (
        .aclk(aclk), .rst(rst),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .cmd_last(cmd_last), .cmd_data(cmd_data),
        .rsp_valid(rsp_valid), .rsp_ready(rsp_ready),
        .rsp_last(rsp_last), .rsp_data(rsp_data),
        .tex_req(tex_req), .tex_addr(tex_addr), .tex_full(tex_full),
        .tex_rvalid(tex_rvalid), .tex_rdata(tex_rdata),
        .commit_fb(commit_fb), .fb_addr(fb_addr), .fb_size(fb_size),
        .fb_committed(fb_committed),
        .pix_valid(pix_valid), .pix_ready(pix_ready),
        .pix_last(pix_last), .pix_data(pix_data),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata)
    );

    sim_memory #(
        .SEED(SEED),
        .FILL_KEY(FILL_KEY)
    ) u_mem (
        .aclk(aclk), .rst(rst),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata)
    );

    always #10 aclk = ~aclk;

    task automatic report_error(input string msg);
        error_count++;
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("Checks failed");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic word_t make_header(input cmd_op_t op, input int count);
        word_t header;
        header = '0;
        header[CMD_OP_LSB +: 4] = op;
        header[CMD_COUNT_WIDTH-1:0] = cmd_count_t'(count);
        return header;
    endfunction

    function automatic word_t pattern_word(input word_t seed_word, input int k);
        return seed_word + 32'(k) * 32'h0001_0101;
    endfunction

    // Untouched locations hold the memory's address-keyed fill pattern
    function automatic word_t expected_word(input addr_t addr);
        if (ref_mem.exists(addr))
            return ref_mem[addr];
        return addr ^ FILL_KEY;
    endfunction

    task automatic send_cmd_word(input word_t data, input logic last);
        cmd_valid = 1'b1;
        cmd_data  = data;
        cmd_last  = last;
        @(posedge aclk);
        while (!cmd_ready)
            @(posedge aclk);
        #2;
        cmd_valid = 1'b0;
        cmd_last  = 1'b0;
    endtask

    task automatic check_memory(input addr_t base, input int count);
        int k;
        for (k = 0; k < count; k++)
            assert (u_mem.read_word(base + k) == ref_mem[base + k])
            else report_error($sformatf("memory at %h holds %h, expected %h", base + k,
                                        u_mem.read_word(base + k), ref_mem[base + k]));
    endtask

    task automatic run_store(input addr_t base, input int count, input word_t seed_word);
        int k;
        send_cmd_word(make_header(OP_STORE, count), 1'b0);
        send_cmd_word(base, 1'b0);
        for (k = 0; k < count; k++)
        begin
            ref_mem[base + k] = pattern_word(seed_word, k);
            send_cmd_word(pattern_word(seed_word, k), k == count - 1);
        end
        assert (!cmd_ready)
        else report_error("cmd_ready high right after the last store word");
        while (!cmd_ready)
        begin
            @(posedge aclk);
            #2;
        end
        check_memory(base, count);
    endtask

    task automatic run_load(input addr_t base, input int count);
        int          k;
        logic [31:0] rand_bits;
        send_cmd_word(make_header(OP_LOAD, count), 1'b0);
        send_cmd_word(base, 1'b1);
        k = 0;
        while (k < count)
        begin
            rand_bits = $random(seed);
            rsp_ready = rand_bits[0];
            @(posedge aclk);
            if (rsp_valid && rsp_ready)
            begin
                assert (rsp_data == expected_word(base + k))
                else report_error($sformatf("load word %0d at %h is %h, expected %h", k,
                                            base + k, rsp_data, expected_word(base + k)));
                assert (rsp_last == (k == count - 1))
                else report_error($sformatf("rsp_last is %b on load word %0d", rsp_last, k));
                k++;
            end
            #2;
        end
        rsp_ready = 1'b0;
        assert (!rsp_valid)
        else report_error("response stream continued past the last word");
    endtask

    task automatic run_texel(input addr_t base, input int count, input logic expect_full);
        int k;
        saw_full = 1'b0;
        k = 0;
        while (k < count)
        begin
            if (!tex_full)
            begin
                tex_req  = 1'b1;
                tex_addr = base + k;
                tex_expect.push_back(expected_word(base + k));
                k++;
            end
            else
                tex_req = 1'b0;
            @(posedge aclk);
            #2;
        end
        tex_req = 1'b0;
        while (tex_expect.size() != 0)
        begin
            @(posedge aclk);
            #2;
        end
        if (expect_full)
            assert (saw_full)
            else report_error("tex_full never rose during a long texel burst");
    endtask

    task automatic run_commit(input addr_t base, input int count, input word_t seed_word);
        int k;
        commit_fb = 1'b1;
        fb_addr   = base;
        fb_size   = FB_SIZE_LG'(count);
        commit_count++;
        @(posedge aclk);
        #2;
        commit_fb = 1'b0;
        for (k = 0; k < count; k++)
        begin
            ref_mem[base + k] = pattern_word(seed_word, k);
            pix_valid = 1'b1;
            pix_data  = pattern_word(seed_word, k);
            pix_last  = (k == count - 1);
            @(posedge aclk);
            while (!pix_ready)
                @(posedge aclk);
            #2;
        end
        pix_valid = 1'b0;
        pix_last  = 1'b0;
        while (!fb_committed)
        begin
            @(posedge aclk);
            #2;
        end
        assert (commit_pulses == commit_count - 1)
        else report_error("fb_committed pulsed before the frame was written");
        check_memory(base, count);
        @(posedge aclk);
        #2;
        assert (commit_pulses == commit_count && !fb_committed)
        else report_error($sformatf("fb_committed pulsed %0d times for %0d commits",
                                    commit_pulses, commit_count));
    endtask

    // Texel data order and the queue-full flag against a pushed/popped count
    always @(negedge aclk)
    begin
        if (!rst)
        begin
            if (tex_rvalid)
            begin
                tex_pops++;
                assert (tex_expect.size() != 0)
                else report_error("tex_rvalid without an outstanding texel read");
                assert (tex_rdata == tex_expect[0])
                else report_error($sformatf("texel data %h, expected %h",
                                            tex_rdata, tex_expect[0]));
                void'(tex_expect.pop_front());
            end
            if (tex_full)
                saw_full = 1'b1;
            assert (tex_full == ((tex_pushes - tex_pops) == TEX_SLOTS))
            else report_error($sformatf("tex_full is %b with %0d reads queued",
                                        tex_full, tex_pushes - tex_pops));
            if (tex_req)
                tex_pushes++;
            if (fb_committed)
                commit_pulses++;
        end
    end

    // A waiting requester may see at most two grants to other peers
    always @(negedge aclk)
    begin
        if (!rst)
        begin
            reqs = {u_dut.fb_req, u_dut.tx_req, u_dut.dma_req};
            acks = {u_dut.fb_ack, u_dut.tx_ack, u_dut.dma_ack};
            for (int p = 0; p < 3; p++)
            begin
                if (acks[p] || !reqs[p])
                    waits[p] = 0;
                else if (acks != 3'b000)
                    waits[p] = waits[p] + 1;
                assert (waits[p] < 3)
                else report_error($sformatf("requester %0d passed over by %0d grants",
                                            p, waits[p]));
            end
        end
    end

    initial
    begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge aclk);
        $display("Timeout: the tests did not finish within %0d cycles", limit_cycles);
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        int total;
        aclk      = 1'b0;
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd_last  = 1'b0;
        cmd_data  = '0;
        rsp_ready = 1'b0;
        tex_req   = 1'b0;
        tex_addr  = '0;
        commit_fb = 1'b0;
        fb_addr   = '0;
        fb_size   = '0;
        pix_valid = 1'b0;
        pix_last  = 1'b0;
        pix_data  = '0;
        seed      = SEED;

        steps[0]  = '{K_STORE,  32'h0000_1000, 16'd8,  32'h1111_0000};
        steps[1]  = '{K_LOAD,   32'h0000_1000, 16'd8,  32'h0000_0000};
        steps[2]  = '{K_STORE,  32'h0000_2000, 16'd16, 32'h2222_0000};
        steps[3]  = '{K_LOAD,   32'h0000_2000, 16'd16, 32'h0000_0000};
        steps[4]  = '{K_TEXEL,  32'h0000_2000, 16'd10, 32'h0000_0000};
        steps[5]  = '{K_COMMIT, 32'h0000_3000, 16'd12, 32'h3333_0000};
        steps[6]  = '{K_TEXEL,  32'h0000_3000, 16'd6,  32'h0000_0000};
        steps[7]  = '{K_LOAD,   32'h0000_3000, 16'd12, 32'h0000_0000};
        steps[8]  = '{K_MIX,    32'h0000_4000, 16'd24, 32'h4444_0000};
        steps[9]  = '{K_LOAD,   32'h0000_4000, 16'd24, 32'h0000_0000};
        steps[10] = '{K_LOAD,   32'h0000_5000, 16'd24, 32'h0000_0000};
        steps[11] = '{K_TEXEL,  32'h0000_6000, 16'd4,  32'h0000_0000};

        total = 0;
        for (int i = 0; i < NUM_STEPS; i++)
            total += steps[i].count;
        limit_cycles = total * 40;

        repeat (3) @(posedge aclk);
        #2;
        assert ({mem_req, cmd_ready, rsp_valid, tex_rvalid, pix_ready, fb_committed} == '0)
        else report_error("an output is active during reset");
        rst = 1'b0;

        for (int i = 0; i < NUM_STEPS; i++)
        begin
            case (steps[i].kind)
                K_STORE:
                    run_store(steps[i].addr, steps[i].count, steps[i].seed);
                K_LOAD:
                    run_load(steps[i].addr, steps[i].count);
                K_TEXEL:
                    run_texel(steps[i].addr, steps[i].count, steps[i].count >= 2 * TEX_SLOTS);
                K_COMMIT:
                    run_commit(steps[i].addr, steps[i].count, steps[i].seed);
                default:
                    // Store, texel burst and commit all compete for the bus
                    fork
                        run_store(steps[i].addr, steps[i].count, steps[i].seed);
                        run_texel(MIX_TEX_BASE, MIX_TEX_COUNT, 1'b0);
                        run_commit(steps[i].addr + MIX_FB_OFFSET, steps[i].count,
                                   ~steps[i].seed);
                    join
            endcase
        end

        if (error_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// ==== filelist.f ====
verilog/raster_mem_pkg.sv
verilog/cmd_dma.sv
verilog/texel_fetch.sv
verilog/fb_writer.sv
verilog/mem_arbiter.sv
verilog/raster_mem_top.sv
sim/sim_memory.sv
sim/tb_raster_mem.sv

// ==== Bender.yml ====
package:
  name: raster_mem

sources:
  - verilog/raster_mem_pkg.sv
  - verilog/cmd_dma.sv
  - verilog/texel_fetch.sv
  - verilog/fb_writer.sv
  - verilog/mem_arbiter.sv
  - verilog/raster_mem_top.sv
  - target: simulation
    files:
      - sim/sim_memory.sv
      - sim/tb_raster_mem.sv
